/* Makefile */
# Verilator build and run of the replay testbench
VERILATOR ?= verilator
TOP       ?= replay_top_tb
FILELIST  ?= replay_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: sim clean

# the run fails unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* cmd_pkg.sv */
`default_nettype none

// command word layout
// opcode sits in the top byte, payload in the low bits
package cmd_pkg;

  localparam int word_w = 64;
  localparam int op_w = 8;
  localparam int payload_w = word_w - op_w;

  // record payload or configuration value
  typedef logic [payload_w-1:0] payload_t;

  // command opcodes, anything else is dropped by the parser
  typedef enum logic [op_w-1:0] {
    // payload low 16 bits: new unit length in cycles
    op_set_unit   = 8'h01,
    // payload low 48 bits: heartbeat period in units
    op_set_hb     = 8'h02,
    // restart the wall clock, no payload
    op_reset_time = 8'h03,
    // payload low 48 bits: capture time of the following records
    op_timestamp  = 8'h04,
    // payload is a record for downstream
    op_data       = 8'h05
  } opcode_e;

  // configuration after reset
  localparam time_pkg::unit_t default_unit_len = time_pkg::unit_t'(8);
  localparam time_pkg::time_t default_hb_every = time_pkg::time_t'(4);

endpackage

`default_nettype wire

/* hb_sender.sv */
`default_nettype none

// heartbeat word toward upstream
// one holding register, a newer pulse replaces a pending time
module hb_sender (
  input  logic            clk,
  input  logic            reset,
  input  logic            send_hb_up_pulse,
  input  time_pkg::time_t time_elapsed,
  output logic            up_valid,
  input  logic            up_ready,
  output time_pkg::time_t up_time
);

  // pending flag
  // a pulse in the same cycle as a transfer keeps it set for the new time
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      up_valid <= 1'b0;
    end else if (send_hb_up_pulse) begin
      up_valid <= 1'b1;
    end else if (up_ready) begin
      up_valid <= 1'b0;
    end
  end

  // wall time sampled on the pulse
  // slow consumers see the newest value
  always_ff @(posedge clk) begin
    if (send_hb_up_pulse) begin
      up_time <= time_elapsed;
    end
  end

endmodule

`default_nettype wire

/* pc_parser.sv */
`default_nettype none

// command decoder
// configuration commands always go through
// data commands load a one-entry output register toward downstream
module pc_parser (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  logic [cmd_pkg::word_w-1:0] cmd_data,
  input  logic                    stall_dn,
  time_mgr_conf_if.parser         conf,
  output logic                    dn_valid,
  input  logic                    dn_ready,
  output cmd_pkg::payload_t       dn_data
);

  cmd_pkg::opcode_e  opcode;
  cmd_pkg::payload_t payload;
  // current word is a record
  logic              is_data;
  // output register empty or drained this cycle
  logic              slot_free;
  // command transfer this cycle
  logic              cmd_fire;
  // record transfer into the output register
  logic              data_load;

  // field split of the command word
  assign opcode = cmd_pkg::opcode_e'(cmd_data[cmd_pkg::word_w-1 -: cmd_pkg::op_w]);
  assign payload = cmd_data[cmd_pkg::payload_w-1:0];
  assign is_data = (opcode == cmd_pkg::op_data);

  assign slot_free = !dn_valid || dn_ready;

  // records wait for the wall clock and for room in the register
  // everything else, unknown opcodes included, is taken at once
  assign cmd_ready = is_data ? (slot_free && !stall_dn) : 1'b1;
  assign cmd_fire = cmd_valid && cmd_ready;
  assign data_load = cmd_fire && is_data;

  // restart pulse, the wall clock takes it on the transfer edge
  assign conf.reset_time = cmd_fire && (opcode == cmd_pkg::op_reset_time);

  // configuration registers, visible the cycle after the transfer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      conf.unit_len <= cmd_pkg::default_unit_len;
      conf.send_hb_up_every <= cmd_pkg::default_hb_every;
      conf.pc_time_elapsed <= '0;
    end else if (cmd_fire) begin
      case (opcode)
        cmd_pkg::op_set_unit: begin
          conf.unit_len <= payload[time_pkg::unit_w-1:0];
        end
        cmd_pkg::op_set_hb: begin
          conf.send_hb_up_every <= payload[time_pkg::time_w-1:0];
        end
        cmd_pkg::op_timestamp: begin
          conf.pc_time_elapsed <= payload[time_pkg::time_w-1:0];
        end
        // a restart also drops the capture time in force
        // so records already stamped do not stall on the new wall clock
        cmd_pkg::op_reset_time: begin
          conf.pc_time_elapsed <= '0;
        end
        // records and unknown opcodes leave the configuration alone
        default: begin
        end
      endcase
    end
  end

  // output register valid
  // a load in the draining cycle keeps it set
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dn_valid <= 1'b0;
    end else if (data_load) begin
      dn_valid <= 1'b1;
    end else if (dn_ready) begin
      dn_valid <= 1'b0;
    end
  end

  // payload only changes on a load, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (data_load) begin
      dn_data <= payload;
    end
  end

endmodule

`default_nettype wire

/* replay_top.f */
time_pkg.sv
cmd_pkg.sv
time_mgr_conf_if.sv
time_unit_pulser.sv
time_mgr.sv
pc_parser.sv
hb_sender.sv
replay_top.sv
replay_top_props.sv
replay_top_tb.sv

/* replay_top.sv */
`default_nettype none

// capture replay top level
// parser feeds the time manager's configuration
// time manager paces the records and the heartbeats
module replay_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cmd_valid,
  output logic                       cmd_ready,
  input  logic [cmd_pkg::word_w-1:0] cmd_data,
  output logic                       dn_valid,
  input  logic                       dn_ready,
  output cmd_pkg::payload_t          dn_data,
  output logic                       up_valid,
  input  logic                       up_ready,
  output time_pkg::time_t            up_time,
  output time_pkg::time_t            time_elapsed,
  output logic                       stall_dn
);

  // heartbeat tick between time manager and sender
  logic send_hb_up_pulse;

  time_mgr_conf_if conf_if ();

  pc_parser pc_parser_inst (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_data  (cmd_data),
    .stall_dn  (stall_dn),
    .conf      (conf_if.parser),
    .dn_valid  (dn_valid),
    .dn_ready  (dn_ready),
    .dn_data   (dn_data)
  );

  // unit tick is internal to the time manager
  time_mgr time_mgr_inst (
    .clk              (clk),
    .reset            (reset),
    .conf             (conf_if.mgr),
    .unit_pulse       (),
    .send_hb_up_pulse (send_hb_up_pulse),
    .time_elapsed     (time_elapsed),
    .stall_dn         (stall_dn)
  );

  hb_sender hb_sender_inst (
    .clk              (clk),
    .reset            (reset),
    .send_hb_up_pulse (send_hb_up_pulse),
    .time_elapsed     (time_elapsed),
    .up_valid         (up_valid),
    .up_ready         (up_ready),
    .up_time          (up_time)
  );

endmodule

`default_nettype wire

/* replay_top_props.sv */
`default_nettype none

// handshake and stall properties, bound into the replay top level
module replay_top_props (
  input logic                       clk,
  input logic                       reset,
  input logic                       cmd_valid,
  input logic [cmd_pkg::word_w-1:0] cmd_data,
  input logic                       dn_valid,
  input logic                       dn_ready,
  input cmd_pkg::payload_t          dn_data,
  input logic                       up_valid,
  input logic                       up_ready,
  input logic                       stall_dn
);

  // failed property count, read by the testbench at the end
  int   fail_count = 0;
  // command word on the bus is a record
  logic data_word;

  assign data_word = (cmd_data[cmd_pkg::word_w-1 -: cmd_pkg::op_w] == cmd_pkg::op_data);

  // a record under back-pressure stays put
  dn_hold: assert property (@(posedge clk) disable iff (reset)
    dn_valid && !dn_ready |=> dn_valid && $stable(dn_data))
    else begin
      fail_count++;
      $error("downstream record dropped or changed under back-pressure");
    end

  // heartbeat word waits for the consumer
  up_hold: assert property (@(posedge clk) disable iff (reset)
    up_valid && !up_ready |=> up_valid)
    else begin
      fail_count++;
      $error("heartbeat word withdrawn before up_ready");
    end

  // a record offered during a stall must not be loaded
  stall_no_load: assert property (@(posedge clk) disable iff (reset)
    cmd_valid && data_word && stall_dn |=> !$rose(dn_valid))
    else begin
      fail_count++;
      $error("record left downstream after a stalled cycle");
    end

endmodule

bind replay_top replay_top_props replay_top_props_inst (
  .clk       (clk),
  .reset     (reset),
  .cmd_valid (cmd_valid),
  .cmd_data  (cmd_data),
  .dn_valid  (dn_valid),
  .dn_ready  (dn_ready),
  .dn_data   (dn_data),
  .up_valid  (up_valid),
  .up_ready  (up_ready),
  .stall_dn  (stall_dn)
);

`default_nettype wire

/* replay_top_tb.sv */
`default_nettype none

// testbench for the capture replay top level
module replay_top_tb;

  logic                       clk;
  logic                       reset;
  logic                       cmd_valid;
  logic                       cmd_ready;
  logic [cmd_pkg::word_w-1:0] cmd_data;
  logic                       dn_valid;
  logic                       dn_ready;
  cmd_pkg::payload_t          dn_data;
  logic                       up_valid;
  logic                       up_ready;
  time_pkg::time_t            up_time;
  time_pkg::time_t            time_elapsed;
  logic                       stall_dn;

  // every command sent, in order, for the reference model
  logic [cmd_pkg::word_w-1:0] cmd_list[$];
  // records still owed downstream and the stamp each one waits for
  cmd_pkg::payload_t exp_data[$];
  time_pkg::time_t   exp_stamp[$];
  // wall clock changes and heartbeat words seen
  int                chg_cycle[$];
  time_pkg::time_t   chg_val[$];
  time_pkg::time_t   hb_seen[$];
  time_pkg::time_t   last_time;
  time_pkg::time_t   stamp;
  time_pkg::time_t   rec_stamp;
  cmd_pkg::payload_t rec_data;
  cmd_pkg::payload_t bp_data[40];
  logic [31:0]       lfsr = 32'he2ec;
  logic              rand_ready;
  int                cycle;
  int                cycle_limit;
  int                last_wait;
  // every downstream transfer, expected or not
  int                dn_count;
  int                start;
  int                mark;
  int                checks;
  int                errors;
  int                tests_run;
  int                tests_failed;

  replay_top replay_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // feedback taps 32 22 2 1
  // one step per bit taken
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // walks the command list up to a point
  // gives the stamp in force (a restart clears it) or the heartbeat period
  function automatic time_pkg::time_t ref_model(input int upto, input logic want_hb);
    time_pkg::time_t cur_stamp;
    time_pkg::time_t hb_every;
    logic [7:0]      op;
    cur_stamp = '0;
    hb_every = cmd_pkg::default_hb_every;
    for (int i = 0; i < upto; i++) begin
      op = cmd_list[i][63:56];
      if (op == cmd_pkg::op_timestamp) cur_stamp = cmd_list[i][47:0];
      if (op == cmd_pkg::op_reset_time) cur_stamp = '0;
      if (op == cmd_pkg::op_set_hb) hb_every = cmd_list[i][47:0];
    end
    return want_hb ? hb_every : cur_stamp;
  endfunction

  task automatic expect_eq(input logic [63:0] got, input logic [63:0] want, input string what);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic step_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // holds the word until the parser takes it
  // owed records go to the expected queues
  task automatic send_cmd(input logic [7:0] op, input cmd_pkg::payload_t payload);
    logic taken;
    cmd_valid = 1'b1;
    cmd_data = {op, payload};
    if (op == cmd_pkg::op_data) begin
      exp_stamp.push_back(ref_model(cmd_list.size(), 1'b0));
      exp_data.push_back(payload);
    end
    cmd_list.push_back({op, payload});
    last_wait = 0;
    do begin
      @(negedge clk);
      taken = cmd_ready;
      last_wait++;
      step_cycles(1);
    end while (!taken);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    @(posedge clk);
    while (exp_data.size() != 0) @(posedge clk);
    #1;
  endtask

  task automatic test_done(input string name);
    tests_run++;
    if (errors == mark) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
    mark = errors;
  endtask

  // cycle count and run limit
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("timeout, run stopped after %0d cycles", cycle);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ready pattern is random only while back-pressure runs
  always @(posedge clk) begin
    #1;
    dn_ready = rand_ready ? rand_bit() : 1'b1;
    up_ready = rand_ready ? rand_bit() : 1'b1;
  end

  // wall clock steps and heartbeat transfers sampled mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (time_elapsed != last_time) begin
        chg_cycle.push_back(cycle);
        chg_val.push_back(time_elapsed);
      end
      last_time = time_elapsed;
      if (up_valid && up_ready) hb_seen.push_back(up_time);
    end
  end

  // compare process pops one expected record per downstream transfer
  always @(negedge clk) begin
    if (!reset && dn_valid && dn_ready) begin
      dn_count++;
      checks++;
      assert (exp_data.size() != 0) else begin
        errors++;
        $display("unexpected downstream record %h at %0t", dn_data, $time);
      end
      if (exp_data.size() != 0) begin
        rec_data = exp_data.pop_front();
        rec_stamp = exp_stamp.pop_front();
        expect_eq(64'(dn_data), 64'(rec_data), "record payload");
        checks++;
        assert (time_elapsed >= rec_stamp) else begin
          errors++;
          $display("** Error at %0t: record left at wall time %0d before stamp %0d",
                   $time, time_elapsed, rec_stamp);
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd_data = '0;
    dn_ready = 1'b1;
    up_ready = 1'b1;
    rand_ready = 1'b0;
    last_time = '0;
    cycle = 0;
    last_wait = 0;
    dn_count = 0;
    start = 0;
    mark = 0;
    checks = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    // unit lengths 8 and 5 times the units waited on
    // 6 for unit steps, 15 for heartbeats, 6 for the stall, 4 stamps under back-pressure
    // plus a few cycles per record and a margin
    cycle_limit = (8 + 5) * (6 + 15 + 6 + 4) + 48 * 8 + 500;
    step_cycles(2);
    reset = 1'b0;

    // unit length of 5 cycles and clock steps by one
    send_cmd(cmd_pkg::op_set_unit, 56'd5);
    step_cycles(3);
    chg_cycle.delete();
    chg_val.delete();
    while (chg_val.size() < 5) step_cycles(1);
    for (int i = 1; i < 5; i++) begin
      expect_eq(64'(chg_cycle[i] - chg_cycle[i-1]), 64'd5, "cycles per unit");
      expect_eq(64'(chg_val[i]), 64'(chg_val[i-1] + 48'd1), "wall clock step");
    end
    test_done("unit length");

    // heartbeat every 3 units
    send_cmd(cmd_pkg::op_set_hb, 56'd3);
    step_cycles(3);
    hb_seen.delete();
    while (hb_seen.size() < 4) step_cycles(1);
    for (int i = 1; i < 4; i++) begin
      expect_eq(64'(hb_seen[i] - hb_seen[i-1]), 64'(ref_model(cmd_list.size(), 1'b1)),
                "heartbeat spacing");
    end
    test_done("heartbeat");

    // stamp 6 units ahead holds the records back
    stamp = time_elapsed + 48'd6;
    send_cmd(cmd_pkg::op_timestamp, 56'(stamp));
    @(negedge clk);
    expect_eq(64'(stall_dn), 64'd1, "stall after timestamp");
    step_cycles(1);
    for (int k = 0; k < 4; k++) send_cmd(cmd_pkg::op_data, 56'h3000 + 56'(k));
    wait_drain();
    test_done("stall");

    // payloads drawn while the ready pattern is idle
    for (int k = 0; k < 40; k++) begin
      for (int b = 0; b < 56; b++) bp_data[k] = {bp_data[k][54:0], rand_bit()};
    end
    start = dn_count;
    hb_seen.delete();
    stamp = time_elapsed;
    @(negedge clk);
    rand_ready = 1'b1;
    step_cycles(1);
    for (int k = 0; k < 40; k++) begin
      if (k % 10 == 0) send_cmd(cmd_pkg::op_timestamp, 56'(stamp + 48'(k / 10 + 1)));
      send_cmd(cmd_pkg::op_data, bp_data[k]);
    end
    wait_drain();
    @(negedge clk);
    rand_ready = 1'b0;
    step_cycles(1);
    expect_eq(64'(dn_count - start), 64'd40, "records delivered");
    for (int i = 1; i < hb_seen.size(); i++) begin
      expect_eq(64'(hb_seen[i] >= hb_seen[i-1]), 64'd1, "heartbeat time order");
    end
    test_done("back-pressure");

    // after a restart the old stamp no longer holds records
    send_cmd(cmd_pkg::op_reset_time, 56'd0);
    @(negedge clk);
    expect_eq(64'(time_elapsed), 64'd1, "wall clock after restart");
    expect_eq(64'(stall_dn), 64'd0, "stall after restart");
    step_cycles(1);
    start = cycle;
    for (int k = 0; k < 3; k++) send_cmd(cmd_pkg::op_data, 56'h5000 + 56'(k));
    wait_drain();
    expect_eq(64'(cycle - start <= 8), 64'd1, "records after restart unstalled");
    test_done("restart");

    // undefined opcode is taken and dropped
    start = dn_count;
    send_cmd(8'hAA, 56'h1234);
    expect_eq(64'(last_wait), 64'd1, "cycles to accept unknown opcode");
    step_cycles(6);
    expect_eq(64'(dn_count - start), 64'd0, "records from unknown opcode");
    test_done("unknown opcode");

    errors += replay_top_inst.replay_top_props_inst.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* time_mgr.sv */
`default_nettype none

// wall clock in time units, heartbeat timing and downstream stall
// records are held back while their capture time is ahead of the wall clock
module time_mgr (
  input  logic            clk,
  input  logic            reset,
  time_mgr_conf_if.mgr    conf,
  output logic            unit_pulse,
  output logic            send_hb_up_pulse,
  output time_pkg::time_t time_elapsed,
  output logic            stall_dn
);

  // units counted since the last heartbeat, starts at 1
  time_pkg::time_t units_since_hb;

  // unit tick from the configured length
  time_unit_pulser unit_pulser_inst (
    .clk           (clk),
    .reset         (reset),
    .clks_per_unit (conf.unit_len),
    .unit_pulse    (unit_pulse)
  );

  // wall clock
  // a restart wins over a unit tick in the same cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      time_elapsed <= time_pkg::time_reset_value;
    end else if (conf.reset_time) begin
      time_elapsed <= time_pkg::time_reset_value;
    end else if (unit_pulse) begin
      time_elapsed <= time_elapsed + time_pkg::time_t'(1);
    end
  end

  // heartbeat counter
  // fires on the unit pulse that completes the period, pulse is seen one cycle later
  // >= catches a period shortened below the current count
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      units_since_hb <= time_pkg::time_t'(1);
      send_hb_up_pulse <= 1'b0;
    end else if (unit_pulse) begin
      if (units_since_hb >= conf.send_hb_up_every) begin
        units_since_hb <= time_pkg::time_t'(1);
        send_hb_up_pulse <= 1'b1;
      end else begin
        units_since_hb <= units_since_hb + time_pkg::time_t'(1);
        send_hb_up_pulse <= 1'b0;
      end
    end else begin
      send_hb_up_pulse <= 1'b0;
    end
  end

  // capture time ahead of wall time, so hold the records
  assign stall_dn = (conf.pc_time_elapsed > time_elapsed);

endmodule

`default_nettype wire

/* time_mgr_conf_if.sv */
`default_nettype none

// configuration path from the command parser to the time manager
interface time_mgr_conf_if;

  // clock cycles per time unit
  time_pkg::unit_t unit_len;
  // heartbeat period in time units
  time_pkg::time_t send_hb_up_every;
  // capture time of the records now in the stream
  time_pkg::time_t pc_time_elapsed;
  // one-cycle restart of the wall clock
  logic reset_time;

  // parser side drives everything
  modport parser (
    output unit_len, send_hb_up_every, pc_time_elapsed, reset_time
  );

  // time manager only reads
  modport mgr (
    input unit_len, send_hb_up_every, pc_time_elapsed, reset_time
  );

endinterface

`default_nettype wire

/* time_pkg.sv */
`default_nettype none

// wall-clock widths and limits shared by the time keeping blocks
package time_pkg;

  // width of wall time and capture time, in time units
  localparam int time_w = 48;

  // width of the unit length, in clock cycles
  localparam int unit_w = 16;

  // wall or capture time value
  typedef logic [time_w-1:0] time_t;

  // clock cycles per time unit
  typedef logic [unit_w-1:0] unit_t;

  // wall clock value after reset or a restart command
  localparam time_t time_reset_value = time_t'(1);

endpackage

`default_nettype wire

/* time_unit_pulser.sv */
`default_nettype none

// one-cycle pulse every clks_per_unit clock cycles
module time_unit_pulser (
  input  logic            clk,
  input  logic            reset,
  input  time_pkg::unit_t clks_per_unit,
  output logic            unit_pulse
);

  // cycles counted in the current unit
  time_pkg::unit_t cnt;
  // last cycle of the unit reached
  logic            cnt_done;

  // zero or one means a pulse on every cycle
  // compare with >= so a shorter length takes effect at once
  always_comb begin
    if (clks_per_unit <= time_pkg::unit_t'(1)) begin
      cnt_done = 1'b1;
    end else begin
      cnt_done = (cnt >= clks_per_unit - time_pkg::unit_t'(1));
    end
  end

  // counter restarts after each pulse
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt <= '0;
      unit_pulse <= 1'b0;
    end else if (cnt_done) begin
      cnt <= '0;
      unit_pulse <= 1'b1;
    end else begin
      cnt <= cnt + time_pkg::unit_t'(1);
      unit_pulse <= 1'b0;
    end
  end

endmodule

`default_nettype wire
